// ==== src/spi_bus_pkg.sv ====
package spi_bus_pkg;

	// ##############################
	// control bus geometry
	// ##############################

	localparam int CTRL_ADDR_W = 8;
	localparam int CTRL_DATA_W = 32;

	typedef logic [CTRL_ADDR_W-1:0] ctrl_addr_t;
	typedef logic [CTRL_DATA_W-1:0] ctrl_data_t;

	// ##############################
	// register map
	// ##############################

	localparam ctrl_addr_t ADDR_PRESCALE = 8'h00;
	localparam ctrl_addr_t ADDR_CS       = 8'h04;
	localparam ctrl_addr_t ADDR_DATA     = 8'h08;
	// cpol in bit 1, cpha in bit 0
	localparam ctrl_addr_t ADDR_MODE     = 8'h0c;

endpackage

// ==== src/spi_cfg_pkg.sv ====
package spi_cfg_pkg;

	// ##############################
	// spi side widths and types
	// ##############################

	localparam int SPI_BYTE_W = 8;
	localparam int PRESCALE_W = 8;
	localparam int HALF_CNT_W = 5;

	typedef logic [SPI_BYTE_W-1:0] spi_byte_t;
	// setting P gives half-periods of P+1 clk cycles
	typedef logic [PRESCALE_W-1:0] prescale_t;
	typedef logic [HALF_CNT_W-1:0] half_cnt_t;

	// last half-period index of a transfer, per cpha
	localparam half_cnt_t HALF_LAST_CPHA1 = 5'd15;
	localparam half_cnt_t HALF_LAST_CPHA0 = 5'd16;

	// ##############################
	// reset defaults
	// ##############################

	localparam prescale_t PRESCALE_RESET = 8'd4;
	localparam logic      CPOL_RESET     = 1'b1;
	localparam logic      CPHA_RESET     = 1'b1;

endpackage

// ==== src/spi_prescaler.sv ====
`timescale 1ns/10ps

module spi_prescaler (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   run,
	input  spi_cfg_pkg::prescale_t period,
	output logic                   tick,
	output logic                   phase_start
);
	import spi_cfg_pkg::*;

	prescale_t count;

	// last and first cycle of the current half-period
	assign tick        = run && count == period;
	assign phase_start = run && count == '0;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			count <= '0;
		end else if (!run) begin
			count <= '0;
		end else if (count == period) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// period only changes while stopped
	assert property (@(posedge clk) disable iff (!resetn) count <= period)
		else $error("prescale count beyond period");

endmodule

// ==== src/spi_shift_reg.sv ====
`timescale 1ns/10ps

module spi_shift_reg (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   load,
	input  logic                   shift_out,
	input  logic                   shift_in,
	input  spi_cfg_pkg::spi_byte_t load_data,
	input  logic                   miso,
	output logic                   mosi,
	output spi_cfg_pkg::spi_byte_t rx_data
);
	import spi_cfg_pkg::*;

	spi_byte_t shift_q;

	// tx bits leave at the top while rx bits enter at the bottom
	assign rx_data = shift_q;

	always_ff @(posedge clk) begin
		if (load) begin
			shift_q <= load_data;
		end else if (shift_in) begin
			shift_q <= {shift_q[SPI_BYTE_W-2:0], miso};
		end
	end

	// msb first
	always_ff @(posedge clk) begin
		if (!resetn) begin
			mosi <= 1'b0;
		end else if (load) begin
			mosi <= load_data[SPI_BYTE_W-1];
		end else if (shift_out) begin
			mosi <= shift_q[SPI_BYTE_W-1];
		end
	end

	// strobes come from different half-periods of the sequence
	assert property (@(posedge clk) disable iff (!resetn)
		$onehot0({load, shift_out, shift_in}))
		else $error("shifter strobes overlap");

endmodule

// ==== src/spi_sequencer.sv ====
`timescale 1ns/10ps

module spi_sequencer (
	input  logic clk,
	input  logic resetn,
	input  logic settle_start,
	input  logic xfer_start,
	input  logic cpha,
	input  logic cpol,
	input  logic tick,
	input  logic phase_start,
	output logic run,
	output logic load,
	output logic shift_out,
	output logic shift_in,
	output logic seq_done,
	output logic sclk
);
	import spi_cfg_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		SETTLE,
		XFER,
		DONE
	} state_t;

	state_t    state;
	half_cnt_t half;
	logic      last_half;
	logic      in_xfer;

	// ##############################
	// state and half-period count
	// ##############################

	assign in_xfer   = state == XFER;
	assign last_half = half == (cpha ? HALF_LAST_CPHA1 : HALF_LAST_CPHA0);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= IDLE;
			half  <= '0;
		end else begin
			case (state)
				IDLE: begin
					half <= '0;
					if (settle_start) begin
						state <= SETTLE;
					end else if (xfer_start) begin
						state <= XFER;
					end
				end
				SETTLE: begin
					if (tick) begin
						state <= DONE;
					end
				end
				XFER: begin
					if (tick) begin
						if (last_half) begin
							state <= DONE;
						end else begin
							half <= half + 1'b1;
						end
					end
				end
				// held strobe is dropped here
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// ##############################
	// strobes and sclk
	// ##############################

	assign run      = state == SETTLE || in_xfer;
	assign seq_done = tick && (state == SETTLE || (in_xfer && last_half));

	// byte is taken from the bus in the request cycle
	assign load = state == IDLE && xfer_start;

	// odd half-periods start on a sampling edge in both modes
	assign shift_in = in_xfer && phase_start && half[0];

	// even ones from 2 to 14 start on a launch edge
	assign shift_out = in_xfer && phase_start && !half[0] && half != '0 &&
		half < HALF_LAST_CPHA1;

	// cpha=1 toggles at the start of half 0, cpha=0 one half later
	assign sclk = cpol ^ (in_xfer && (half[0] ^ cpha));

	assert property (@(posedge clk) disable iff (!resetn) !(settle_start && xfer_start))
		else $error("settle and transfer requested together");

	assert property (@(posedge clk) disable iff (!resetn) seq_done |=> !seq_done)
		else $error("seq_done longer than one cycle");

endmodule

// ==== src/spi_regs.sv ====
`timescale 1ns/10ps

module spi_regs #(
	parameter int CS_LENGTH = 32
) (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    ctrl_wr,
	input  logic                    ctrl_rd,
	input  spi_bus_pkg::ctrl_addr_t ctrl_addr,
	input  spi_bus_pkg::ctrl_data_t ctrl_wdat,
	output spi_bus_pkg::ctrl_data_t ctrl_rdat,
	output logic                    ctrl_done,
	input  spi_cfg_pkg::spi_byte_t  rx_data,
	input  logic                    seq_done,
	output spi_cfg_pkg::prescale_t  prescale,
	output logic [CS_LENGTH-1:0]    cs,
	output logic                    cpol,
	output logic                    cpha,
	output spi_cfg_pkg::spi_byte_t  tx_data,
	output logic                    settle_start,
	output logic                    xfer_start
);
	import spi_bus_pkg::*;
	import spi_cfg_pkg::*;

	logic done_q;
	logic op_busy;
	logic accept;
	logic settle_addr;

	// new access only when nothing is completing or in flight
	assign accept      = !done_q && !op_busy;
	assign settle_addr = ctrl_addr == ADDR_CS || ctrl_addr == ADDR_MODE;

	// requests stay up as long as the bus holds the strobe
	assign settle_start = ctrl_wr && settle_addr;
	assign xfer_start   = ctrl_wr && ctrl_addr == ADDR_DATA;
	assign tx_data      = spi_byte_t'(ctrl_wdat);

	assign ctrl_done = done_q || seq_done;

	// ##############################
	// config registers
	// ##############################

	always_ff @(posedge clk) begin
		if (!resetn) begin
			done_q   <= 1'b0;
			op_busy  <= 1'b0;
			prescale <= PRESCALE_RESET;
			cs       <= '1;
			cpol     <= CPOL_RESET;
			cpha     <= CPHA_RESET;
		end else begin
			done_q <= 1'b0;
			if (seq_done) begin
				op_busy <= 1'b0;
			end
			if (accept && ctrl_wr) begin
				case (ctrl_addr)
					ADDR_PRESCALE: begin
						prescale <= prescale_t'(ctrl_wdat);
						done_q   <= 1'b1;
					end
					ADDR_CS: begin
						cs      <= CS_LENGTH'(ctrl_wdat);
						op_busy <= 1'b1;
					end
					ADDR_MODE: begin
						{cpol, cpha} <= ctrl_wdat[1:0];
						op_busy      <= 1'b1;
					end
					ADDR_DATA: op_busy <= 1'b1;
					default: done_q <= 1'b1;
				endcase
			end
			if (accept && ctrl_rd) begin
				done_q <= 1'b1;
			end
		end
	end

	// readback, valid with done_q
	always_ff @(posedge clk) begin
		if (accept && ctrl_rd) begin
			case (ctrl_addr)
				ADDR_PRESCALE: ctrl_rdat <= ctrl_data_t'(prescale);
				ADDR_CS:       ctrl_rdat <= ctrl_data_t'(cs);
				ADDR_DATA:     ctrl_rdat <= ctrl_data_t'(rx_data);
				ADDR_MODE:     ctrl_rdat <= ctrl_data_t'({cpol, cpha});
				default:       ctrl_rdat <= '0;
			endcase
		end
	end

	// sequencer only finishes what this block started
	assert property (@(posedge clk) disable iff (!resetn) seq_done |-> op_busy)
		else $error("seq_done without a pending write");

endmodule

// ==== src/spi_master.sv ====
`timescale 1ns/10ps

module spi_master #(
	parameter int CS_LENGTH = 32
) (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    ctrl_wr,
	input  logic                    ctrl_rd,
	input  spi_bus_pkg::ctrl_addr_t ctrl_addr,
	input  spi_bus_pkg::ctrl_data_t ctrl_wdat,
	output spi_bus_pkg::ctrl_data_t ctrl_rdat,
	output logic                    ctrl_done,
	output logic [CS_LENGTH-1:0]    cs,
	output logic                    mosi,
	input  logic                    miso,
	output logic                    sclk
);
	import spi_cfg_pkg::*;

	prescale_t prescale;
	spi_byte_t tx_data;
	spi_byte_t rx_data;
	logic      cpol;
	logic      cpha;
	logic      settle_start;
	logic      xfer_start;
	logic      seq_done;
	logic      run;
	logic      tick;
	logic      phase_start;
	logic      load;
	logic      shift_out;
	logic      shift_in;

	spi_regs #(
		.CS_LENGTH(CS_LENGTH)
	) u_spi_regs (
		.clk         (clk),
		.resetn      (resetn),
		.ctrl_wr     (ctrl_wr),
		.ctrl_rd     (ctrl_rd),
		.ctrl_addr   (ctrl_addr),
		.ctrl_wdat   (ctrl_wdat),
		.ctrl_rdat   (ctrl_rdat),
		.ctrl_done   (ctrl_done),
		.rx_data     (rx_data),
		.seq_done    (seq_done),
		.prescale    (prescale),
		.cs          (cs),
		.cpol        (cpol),
		.cpha        (cpha),
		.tx_data     (tx_data),
		.settle_start(settle_start),
		.xfer_start  (xfer_start)
	);

	spi_sequencer u_spi_sequencer (
		.clk         (clk),
		.resetn      (resetn),
		.settle_start(settle_start),
		.xfer_start  (xfer_start),
		.cpha        (cpha),
		.cpol        (cpol),
		.tick        (tick),
		.phase_start (phase_start),
		.run         (run),
		.load        (load),
		.shift_out   (shift_out),
		.shift_in    (shift_in),
		.seq_done    (seq_done),
		.sclk        (sclk)
	);

	spi_prescaler u_spi_prescaler (
		.clk        (clk),
		.resetn     (resetn),
		.run        (run),
		.period     (prescale),
		.tick       (tick),
		.phase_start(phase_start)
	);

	spi_shift_reg u_spi_shift_reg (
		.clk      (clk),
		.resetn   (resetn),
		.load     (load),
		.shift_out(shift_out),
		.shift_in (shift_in),
		.load_data(tx_data),
		.miso     (miso),
		.mosi     (mosi),
		.rx_data  (rx_data)
	);

endmodule

// ==== verification/spi_slave_model.sv ====
`timescale 1ns/10ps

module spi_slave_model (
	input  logic                   clk,
	input  logic                   cs_n,
	input  logic                   sclk,
	input  logic                   mosi,
	input  logic                   cpha,
	input  spi_cfg_pkg::spi_byte_t tx_byte,
	output logic                   miso,
	output spi_cfg_pkg::spi_byte_t rx_byte,
	output int                     sample_edges
);
	import spi_cfg_pkg::*;

	logic      sclk_q   = 1'b1;
	logic      miso_q   = 1'b0;
	int        edge_cnt = 0;
	int        bit_cnt  = 0;
	int        samples  = 0;
	spi_byte_t tx_shift = '0;
	spi_byte_t rx_shift = '0;
	spi_byte_t rx_q     = '0;
	logic      sclk_edge;

	assign miso         = miso_q;
	assign rx_byte      = rx_q;
	assign sample_edges = samples;

	// edges are seen one clk late, where mosi has settled
	assign sclk_edge = !cs_n && sclk != sclk_q;

	always @(posedge clk) begin
		sclk_q <= sclk;
		if (cs_n) begin
			edge_cnt <= 0;
			bit_cnt  <= 0;
			samples  <= 0;
		end else if (sclk_edge) begin
			edge_cnt <= (edge_cnt + 1) % 16;
			// odd edges sample for cpha=0, even edges for cpha=1
			if (edge_cnt[0] == cpha) begin
				rx_shift <= {rx_shift[6:0], mosi};
				samples  <= samples + 1;
				if (bit_cnt == 7) begin
					rx_q    <= {rx_shift[6:0], mosi};
					bit_cnt <= 0;
				end else begin
					bit_cnt <= bit_cnt + 1;
				end
			end else if (edge_cnt == 0) begin
				miso_q <= tx_byte[7];
			end else begin
				miso_q   <= tx_shift[7];
				tx_shift <= tx_shift << 1;
			end
		end

		// between bytes the next one is staged
		if (!sclk_edge && edge_cnt == 0) begin
			tx_shift <= tx_byte << 1;
			if (!cpha) begin
				miso_q <= tx_byte[7];
			end
		end
	end

endmodule

// ==== verification/tb_spi_master.sv ====
`timescale 1ns/10ps

module tb_spi_master;
	import spi_bus_pkg::*;
	import spi_cfg_pkg::*;

	localparam int CS_LENGTH   = 32;
	localparam int BUS_TIMEOUT = 20000;

	logic                 clk;
	logic                 resetn;
	logic                 ctrl_wr;
	logic                 ctrl_rd;
	ctrl_addr_t           ctrl_addr;
	ctrl_data_t           ctrl_wdat;
	ctrl_data_t           ctrl_rdat;
	logic                 ctrl_done;
	logic [CS_LENGTH-1:0] cs;
	logic                 mosi;
	logic                 miso;
	logic                 sclk;

	logic      slave_cpha;
	spi_byte_t slave_tx;
	spi_byte_t slave_rx;
	int        slave_samples;

	string      test_name;
	int         errors;
	int         case_errors;
	int         tests_passed;
	int         tests_failed;
	logic       sclk_trace[$];
	int         last_latency;
	ctrl_data_t rd_data;
	prescale_t  cur_p;
	logic       cur_cpol;
	logic       cur_cpha;
	int         seed;

	spi_master #(
		.CS_LENGTH(CS_LENGTH)
	) u_spi_master (
		.clk      (clk),
		.resetn   (resetn),
		.ctrl_wr  (ctrl_wr),
		.ctrl_rd  (ctrl_rd),
		.ctrl_addr(ctrl_addr),
		.ctrl_wdat(ctrl_wdat),
		.ctrl_rdat(ctrl_rdat),
		.ctrl_done(ctrl_done),
		.cs       (cs),
		.mosi     (mosi),
		.miso     (miso),
		.sclk     (sclk)
	);

	spi_slave_model u_spi_slave_model (
		.clk         (clk),
		.cs_n        (cs[0]),
		.sclk        (sclk),
		.mosi        (mosi),
		.cpha        (slave_cpha),
		.tx_byte     (slave_tx),
		.miso        (miso),
		.rx_byte     (slave_rx),
		.sample_edges(slave_samples)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	// ##############################
	// bus access
	// ##############################

	// sclk is traced once per clk while the access is in flight
	task automatic bus_access(input logic wr, input ctrl_addr_t addr, input ctrl_data_t wdat);
		int n;
		n = 0;
		sclk_trace.delete();
		@(posedge clk);
		ctrl_wr   <= wr;
		ctrl_rd   <= !wr;
		ctrl_addr <= addr;
		ctrl_wdat <= wdat;
		@(posedge clk);
		do begin
			@(posedge clk);
			n++;
			sclk_trace.push_back(sclk);
		end while (!ctrl_done && n < BUS_TIMEOUT);
		ctrl_wr <= 1'b0;
		ctrl_rd <= 1'b0;
		if (ctrl_done) begin
			rd_data      = ctrl_rdat;
			last_latency = n;
		end else begin
			$display("%s: ctrl_done did not arrive within %0d cycles", test_name, BUS_TIMEOUT);
			$display("RESULT: FAIL");
			$finish;
		end
	endtask

	task automatic bus_write(input ctrl_addr_t addr, input ctrl_data_t wdat);
		bus_access(1'b1, addr, wdat);
	endtask

	task automatic bus_read(input ctrl_addr_t addr, output ctrl_data_t data);
		bus_access(1'b0, addr, '0);
		data = rd_data;
	endtask

	// ##############################
	// reference and compares
	// ##############################

	// msb first, one bit each way per sampling edge
	function automatic void spi_expect(input spi_byte_t tx, input spi_byte_t slave,
		output spi_byte_t capture, output spi_byte_t readback);
		int i;
		capture  = '0;
		readback = '0;
		for (i = 7; i >= 0; i--) begin
			capture  = {capture[6:0], tx[i]};
			readback = {readback[6:0], slave[i]};
		end
	endfunction

	task automatic check_data(input string what, input ctrl_data_t exp, input ctrl_data_t act);
		if (exp !== act) begin
			errors++;
			$display("ERR %s %s: expected 0x%08h actual 0x%08h", test_name, what, exp, act);
		end
	endtask

	task automatic check_byte(input string what, input spi_byte_t exp, input spi_byte_t act);
		if (exp !== act) begin
			errors++;
			$display("ERR %s %s: expected 0x%02h actual 0x%02h", test_name, what, exp, act);
		end
	endtask

	task automatic check_level(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			errors++;
			$display("ERR %s %s: expected %b actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		if (exp != act) begin
			errors++;
			$display("ERR %s %s: expected %0d actual %0d", test_name, what, exp, act);
		end
	endtask

	task automatic begin_case(input string name);
		test_name   = name;
		case_errors = errors;
	endtask

	task automatic report_case;
		if (errors == case_errors) begin
			tests_passed++;
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, errors - case_errors);
		end
	endtask

	// ##############################
	// transfer helpers
	// ##############################

	task automatic configure(input prescale_t p, input logic [1:0] mode);
		bus_write(ADDR_PRESCALE, ctrl_data_t'(p));
		bus_write(ADDR_MODE, ctrl_data_t'(mode));
		cur_p      = p;
		cur_cpol   = mode[1];
		cur_cpha   = mode[0];
		slave_cpha <= mode[0];
		check_level("sclk idle after mode write", mode[1], sclk);
	endtask

	// sclk toggles at every half-period start, from half 0 when cpha=1
	task automatic check_timing;
		int   half_len;
		int   i;
		logic exp_lvl;
		logic seen_bad;
		half_len = int'(cur_p) + 1;
		seen_bad = 1'b0;
		check_count("transfer cycles", (cur_cpha ? 16 : 17) * half_len, last_latency);
		for (i = 0; i < sclk_trace.size(); i++) begin
			exp_lvl = cur_cpol ^ (((i / half_len) + cur_cpha) % 2 == 1);
			if (!seen_bad && sclk_trace[i] !== exp_lvl) begin
				seen_bad = 1'b1;
				check_level($sformatf("sclk in cycle %0d", i), exp_lvl, sclk_trace[i]);
			end
		end
	endtask

	// one byte exchange with cs[0] already low
	task automatic exchange(input spi_byte_t tx, input spi_byte_t sb);
		spi_byte_t  exp_cap;
		spi_byte_t  exp_rd;
		ctrl_data_t rd;
		spi_expect(tx, sb, exp_cap, exp_rd);
		slave_tx <= sb;
		bus_write(ADDR_DATA, ctrl_data_t'(tx));
		check_timing();
		bus_read(ADDR_DATA, rd);
		check_data("data readback", ctrl_data_t'(exp_rd), rd);
		check_byte("slave capture", exp_cap, slave_rx);
	endtask

	// ##############################
	// tests
	// ##############################

	task automatic reset_defaults;
		ctrl_data_t rd;
		begin_case("reset_defaults");
		check_level("sclk", 1'b1, sclk);
		check_level("mosi", 1'b0, mosi);
		check_level("ctrl_done", 1'b0, ctrl_done);
		check_data("cs pins", ctrl_data_t'({CS_LENGTH{1'b1}}), ctrl_data_t'(cs));
		bus_read(ADDR_PRESCALE, rd);
		check_data("prescale", 32'd4, rd);
		bus_read(ADDR_CS, rd);
		check_data("cs", ctrl_data_t'({CS_LENGTH{1'b1}}), rd);
		bus_read(ADDR_MODE, rd);
		check_data("mode", 32'd3, rd);
		report_case();
	endtask

	task automatic reg_readback;
		ctrl_data_t p;
		ctrl_data_t c;
		ctrl_data_t m;
		ctrl_data_t rd;
		begin_case("reg_readback");
		repeat (4) begin
			p = $urandom();
			c = $urandom();
			m = $urandom();
			bus_write(ADDR_PRESCALE, p);
			check_count("prescale write latency", 1, last_latency);
			bus_read(ADDR_PRESCALE, rd);
			check_data("prescale", p & 32'hff, rd);
			bus_write(ADDR_CS, c);
			check_count("cs write latency", int'(p[7:0]) + 1, last_latency);
			bus_read(ADDR_CS, rd);
			check_data("cs", c & ctrl_data_t'({CS_LENGTH{1'b1}}), rd);
			bus_write(ADDR_MODE, m);
			check_level("sclk idle", m[1], sclk);
			bus_read(ADDR_MODE, rd);
			check_data("mode", m & 32'h3, rd);
		end
		bus_read(8'h10, rd);
		check_data("unknown address", 32'h0, rd);
		bus_write(ADDR_CS, '1);
		report_case();
	endtask

	task automatic mode_transfers;
		int mode;
		begin_case("mode_transfers");
		for (mode = 0; mode < 4; mode++) begin
			configure(prescale_t'($urandom_range(0, 3)), 2'(mode));
			bus_write(ADDR_CS, ~ctrl_data_t'(1));
			exchange(spi_byte_t'($urandom()), spi_byte_t'($urandom()));
			check_count("sampling edges", 8, slave_samples);
			bus_write(ADDR_CS, '1);
		end
		report_case();
	endtask

	task automatic prescale_timing;
		begin_case("prescale_timing");
		repeat (8) begin
			configure(prescale_t'($urandom_range(0, 7)), 2'($urandom_range(0, 3)));
			bus_write(ADDR_CS, ~ctrl_data_t'(1));
			exchange(spi_byte_t'($urandom()), spi_byte_t'($urandom()));
			bus_write(ADDR_CS, '1);
		end
		report_case();
	endtask

	task automatic back_to_back;
		begin_case("back_to_back");
		configure(prescale_t'($urandom_range(0, 3)), 2'($urandom_range(0, 3)));
		bus_write(ADDR_CS, ~ctrl_data_t'(1));
		repeat (4) begin
			exchange(spi_byte_t'($urandom()), spi_byte_t'($urandom()));
			check_level("sclk between transfers", cur_cpol, sclk);
		end
		bus_write(ADDR_CS, '1);
		report_case();
	endtask

	initial begin
		seed = 32'h89d89cc8;
		void'($urandom(seed));
		errors       = 0;
		case_errors  = 0;
		tests_passed = 0;
		tests_failed = 0;
		test_name    = "reset";
		resetn       = 1'b0;
		ctrl_wr      = 1'b0;
		ctrl_rd      = 1'b0;
		ctrl_addr    = '0;
		ctrl_wdat    = '0;
		slave_cpha   = 1'b1;
		slave_tx     = '0;
		cur_p        = 8'd4;
		cur_cpol     = 1'b1;
		cur_cpha     = 1'b1;
		repeat (4) @(posedge clk);
		resetn <= 1'b1;

		reset_defaults();
		reg_readback();
		mode_transfers();
		prescale_timing();
		back_to_back();

		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
src/spi_bus_pkg.sv
src/spi_cfg_pkg.sv
src/spi_prescaler.sv
src/spi_shift_reg.sv
src/spi_sequencer.sv
src/spi_regs.sv
src/spi_master.sv
verification/spi_slave_model.sv
verification/tb_spi_master.sv
